//--- Makefile
# Verilator build and run of the MCU control testbench

VERILATOR ?= verilator
TOP       ?= tb_mcu_ctrl
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, pass only on the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FLIST) $(shell grep -v '^+' $(FLIST)) mcu_ctrl_config.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+.
mcu_irq_pkg.sv
mcu_pwr_pkg.sv
irq_vector_map.sv
power_domain_ctrl.sv
power_manager.sv
mcu_ctrl_top.sv
mcu_ctrl_chk.sv
tb_mcu_ctrl.sv

//--- irq_vector_map.sv
/*
  core interrupt vector assembly, sticky fast pending bits
*/

`timescale 1ns/100ps

`include "mcu_ctrl_config.svh"

module irq_vector_map (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   irq_software_i,
  input  logic                   irq_external_i,
  input  logic                   timer0_intr_i,
  input  mcu_irq_pkg::fast_irq_t fast_src_i,
  input  mcu_irq_pkg::fast_irq_t fast_clr_i,
  output mcu_irq_pkg::irq_vec_t  irq_o,
  output mcu_irq_pkg::fast_irq_t irq_pending_o
);

  localparam int FAST_W = $bits(mcu_irq_pkg::fast_irq_t);

  mcu_irq_pkg::fast_irq_t pend_d;
  mcu_irq_pkg::fast_irq_t pend_q;
  mcu_irq_pkg::irq_vec_t  irq_d;
  mcu_irq_pkg::irq_vec_t  irq_q;

  // set wins over clear when both land in one cycle
  assign pend_d = (pend_q & ~fast_clr_i) | fast_src_i;

  always_comb begin
    irq_d                                  = '0;
    irq_d[`MCU_IRQ_SW_BIT]                 = irq_software_i;
    irq_d[`MCU_IRQ_TIMER_BIT]              = timer0_intr_i;
    irq_d[`MCU_IRQ_EXT_BIT]                = irq_external_i;
    irq_d[`MCU_IRQ_FAST_BASE +: FAST_W]    = pend_d;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  // vector register, fast bits follow pending in the same edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o         = irq_q;
  assign irq_pending_o = pend_q;

endmodule

//--- mcu_ctrl_chk.sv
/*
  ordering assertions on the power controls of one domain sequencer
*/

`timescale 1ns/100ps

module mcu_ctrl_chk (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input mcu_pwr_pkg::pwr_ctrl_t ctrl_i
);

  // switch or retention only while the domain is isolated
  iso_covers_switch: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (!ctrl_i.pwrgate_en_n || !ctrl_i.retentive_en_n) |-> !ctrl_i.isogate_en_n
  ) else $error("switch or retention active while isolation is released");

  // a switched-off domain is held in reset
  rst_covers_switch: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !ctrl_i.pwrgate_en_n |-> !ctrl_i.rst_n
  ) else $error("power switch active while reset is released");

  // isolation only with the clock gated
  clk_covers_iso: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !ctrl_i.isogate_en_n |-> !ctrl_i.clkgate_en_n
  ) else $error("isolation active while the clock is running");

endmodule

//--- mcu_ctrl_config.svh
/*
  bank count and interrupt vector bit positions
*/

`ifndef MCU_CTRL_CONFIG_SVH
`define MCU_CTRL_CONFIG_SVH

// retentive memory banks under power control
`define MCU_NUM_BANKS 2

// machine software interrupt
`define MCU_IRQ_SW_BIT 3

// machine timer interrupt, fed by timer 0
`define MCU_IRQ_TIMER_BIT 7

// machine external interrupt
`define MCU_IRQ_EXT_BIT 11

// first of the sixteen fast interrupt lines
`define MCU_IRQ_FAST_BASE 16

`endif

//--- mcu_ctrl_top.sv
/*
  MCU control top: interrupt vector map, power manager, CPU reset merge
*/

`timescale 1ns/100ps

`include "mcu_ctrl_config.svh"

module mcu_ctrl_top (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        irq_software_i,
  input  logic                                        irq_external_i,
  input  mcu_irq_pkg::timer_irq_t                     timer_intr_i,
  input  mcu_irq_pkg::fast_irq_t                      fast_src_i,
  input  mcu_irq_pkg::fast_irq_t                      fast_clr_i,
  input  logic                                        core_sleep_i,
  input  logic                                        cpu_gate_en_i,
  input  logic                                        periph_off_i,
  input  mcu_pwr_pkg::bank_vec_t                      bank_off_i,
  input  logic                                        cpu_ack_ni,
  input  logic                                        periph_ack_ni,
  input  logic                                        debug_rst_ni,
  output mcu_irq_pkg::irq_vec_t                       irq_o,
  output mcu_irq_pkg::fast_irq_t                      irq_pending_o,
  output mcu_pwr_pkg::pwr_ctrl_t                      cpu_ctrl_o,
  output mcu_pwr_pkg::pwr_ctrl_t                      periph_ctrl_o,
  output mcu_pwr_pkg::pwr_ctrl_t [`MCU_NUM_BANKS-1:0] bank_ctrl_o,
  output logic                                        cpu_on_o,
  output logic                                        periph_on_o,
  output mcu_pwr_pkg::bank_vec_t                      bank_on_o,
  output logic                                        cpu_rst_no
);

  mcu_irq_pkg::fast_irq_t fast_merged;

  // timers 1 to 3 share fast lines 0 to 2 with the external fast sources
  assign fast_merged = fast_src_i | mcu_irq_pkg::fast_irq_t'(timer_intr_i[3:1]);

  irq_vector_map irq_map_i (
    .clk_i,
    .arst_n_i,
    .irq_software_i,
    .irq_external_i,
    .timer0_intr_i(timer_intr_i[0]),
    .fast_src_i   (fast_merged),
    .fast_clr_i,
    .irq_o,
    .irq_pending_o
  );

  power_manager power_manager_i (
    .clk_i,
    .arst_n_i,
    .irq_i(irq_o),
    .core_sleep_i,
    .cpu_gate_en_i,
    .periph_off_i,
    .bank_off_i,
    .cpu_ack_ni,
    .periph_ack_ni,
    .cpu_ctrl_o,
    .periph_ctrl_o,
    .bank_ctrl_o,
    .cpu_on_o,
    .periph_on_o,
    .bank_on_o
  );

  // debug non-debug-mode reset also holds the core in reset
  assign cpu_rst_no = cpu_ctrl_o.rst_n && debug_rst_ni;

endmodule

//--- mcu_irq_pkg.sv
/*
  interrupt vector, fast line and timer types
*/

package mcu_irq_pkg;

  // full core interrupt vector
  typedef logic [31:0] irq_vec_t;

  // fast sources and their sticky pending bits
  typedef logic [15:0] fast_irq_t;

  // timer 0 is the machine timer, 1 to 3 go to fast lines
  typedef logic [3:0] timer_irq_t;

endpackage

//--- mcu_pwr_pkg.sv
/*
  power-control struct, sequencer states, bank vector type
*/

`include "mcu_ctrl_config.svh"

package mcu_pwr_pkg;

  // all controls are active low, all high means domain fully on
  typedef struct packed {
    logic clkgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic pwrgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_t;

  typedef enum logic [3:0] {
    ON,
    CLK_OFF,
    ISO_ON,
    RST_ON,
    SWITCH_OFF,
    OFF,
    SWITCH_ON,
    RST_OFF,
    ISO_OFF
  } pwr_state_e;

  typedef logic [`MCU_NUM_BANKS-1:0] bank_vec_t;

endpackage

//--- power_domain_ctrl.sv
/*
  power sequencer for one domain: clock, isolation, reset, switch
  or retention on the way down, reverse order on the way up
*/

`timescale 1ns/100ps

module power_domain_ctrl #(
  parameter int RETENTIVE = 0
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   off_req_i,
  input  logic                   ack_ni,
  output mcu_pwr_pkg::pwr_ctrl_t ctrl_o,
  output logic                   on_o
);

  localparam bit IS_RET = (RETENTIVE != 0);

  mcu_pwr_pkg::pwr_state_e state_d;
  mcu_pwr_pkg::pwr_state_e state_q;
  mcu_pwr_pkg::pwr_ctrl_t  ctrl_d;
  mcu_pwr_pkg::pwr_ctrl_t  ctrl_q;

  logic clk_gated;
  logic iso_active;
  logic rst_active;
  logic sw_active;

  // retention needs no switch handshake
  logic sw_down_done;
  logic sw_up_done;

  assign sw_down_done = IS_RET || !ack_ni;
  assign sw_up_done   = IS_RET || ack_ni;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mcu_pwr_pkg::ON: begin
        if (off_req_i) begin
          state_d = mcu_pwr_pkg::CLK_OFF;
        end
      end
      mcu_pwr_pkg::CLK_OFF:  state_d = mcu_pwr_pkg::ISO_ON;
      mcu_pwr_pkg::ISO_ON:   state_d = mcu_pwr_pkg::RST_ON;
      mcu_pwr_pkg::RST_ON:   state_d = mcu_pwr_pkg::SWITCH_OFF;
      mcu_pwr_pkg::SWITCH_OFF: begin
        if (sw_down_done) begin
          state_d = mcu_pwr_pkg::OFF;
        end
      end
      mcu_pwr_pkg::OFF: begin
        if (!off_req_i) begin
          state_d = mcu_pwr_pkg::SWITCH_ON;
        end
      end
      mcu_pwr_pkg::SWITCH_ON: begin
        if (sw_up_done) begin
          state_d = mcu_pwr_pkg::RST_OFF;
        end
      end
      mcu_pwr_pkg::RST_OFF:  state_d = mcu_pwr_pkg::ISO_OFF;
      mcu_pwr_pkg::ISO_OFF:  state_d = mcu_pwr_pkg::ON;
      default:               state_d = mcu_pwr_pkg::ON;
    endcase
  end

  // which controls are asserted in the next state
  assign clk_gated  = (state_d != mcu_pwr_pkg::ON);
  assign iso_active = state_d inside {mcu_pwr_pkg::ISO_ON, mcu_pwr_pkg::RST_ON,
                                      mcu_pwr_pkg::SWITCH_OFF, mcu_pwr_pkg::OFF,
                                      mcu_pwr_pkg::SWITCH_ON, mcu_pwr_pkg::RST_OFF};
  assign rst_active = state_d inside {mcu_pwr_pkg::RST_ON, mcu_pwr_pkg::SWITCH_OFF,
                                      mcu_pwr_pkg::OFF, mcu_pwr_pkg::SWITCH_ON};
  assign sw_active  = state_d inside {mcu_pwr_pkg::SWITCH_OFF, mcu_pwr_pkg::OFF};

  always_comb begin
    ctrl_d.clkgate_en_n   = !clk_gated;
    ctrl_d.isogate_en_n   = !iso_active;
    ctrl_d.rst_n          = !rst_active;
    ctrl_d.pwrgate_en_n   = !(sw_active && !IS_RET);
    ctrl_d.retentive_en_n = !(sw_active && IS_RET);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= mcu_pwr_pkg::ON;
      ctrl_q  <= '1;
    end else begin
      state_q <= state_d;
      ctrl_q  <= ctrl_d;
    end
  end

  assign ctrl_o = ctrl_q;
  assign on_o   = (state_q == mcu_pwr_pkg::ON);

endmodule

//--- power_manager.sv
/*
  always-on power manager: CPU, peripheral and memory bank sequencers
*/

`timescale 1ns/100ps

`include "mcu_ctrl_config.svh"

module power_manager (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  mcu_irq_pkg::irq_vec_t                       irq_i,
  input  logic                                        core_sleep_i,
  input  logic                                        cpu_gate_en_i,
  input  logic                                        periph_off_i,
  input  mcu_pwr_pkg::bank_vec_t                      bank_off_i,
  input  logic                                        cpu_ack_ni,
  input  logic                                        periph_ack_ni,
  output mcu_pwr_pkg::pwr_ctrl_t                      cpu_ctrl_o,
  output mcu_pwr_pkg::pwr_ctrl_t                      periph_ctrl_o,
  output mcu_pwr_pkg::pwr_ctrl_t [`MCU_NUM_BANKS-1:0] bank_ctrl_o,
  output logic                                        cpu_on_o,
  output logic                                        periph_on_o,
  output mcu_pwr_pkg::bank_vec_t                      bank_on_o
);

  logic cpu_wake;
  logic cpu_sleep_req;
  logic cpu_off_req;

  assign cpu_wake      = |irq_i;
  assign cpu_sleep_req = core_sleep_i && cpu_gate_en_i && !cpu_wake;

  // once off, only an interrupt brings the core back
  assign cpu_off_req = cpu_on_o ? cpu_sleep_req : !cpu_wake;

  power_domain_ctrl #(
    .RETENTIVE(0)
  ) cpu_domain_i (
    .clk_i,
    .arst_n_i,
    .off_req_i(cpu_off_req),
    .ack_ni   (cpu_ack_ni),
    .ctrl_o   (cpu_ctrl_o),
    .on_o     (cpu_on_o)
  );

  power_domain_ctrl #(
    .RETENTIVE(0)
  ) periph_domain_i (
    .clk_i,
    .arst_n_i,
    .off_req_i(periph_off_i),
    .ack_ni   (periph_ack_ni),
    .ctrl_o   (periph_ctrl_o),
    .on_o     (periph_on_o)
  );

  // banks keep contents, no switch acknowledge
  for (genvar b = 0; b < `MCU_NUM_BANKS; b++) begin : gen_bank
    power_domain_ctrl #(
      .RETENTIVE(1)
    ) bank_domain_i (
      .clk_i,
      .arst_n_i,
      .off_req_i(bank_off_i[b]),
      .ack_ni   (1'b0),
      .ctrl_o   (bank_ctrl_o[b]),
      .on_o     (bank_on_o[b])
    );
  end

endmodule

//--- tb_mcu_ctrl.sv
/*
  testbench for mcu_ctrl_top with a table of interrupt, fast pending and
  power sequencing tests, per-test results and a closing summary
*/

`timescale 1ns/100ps

`include "mcu_ctrl_config.svh"

module tb_mcu_ctrl;

  localparam int NUM_TESTS   = 16;
  localparam int PWR_TIMEOUT = 64;

  // control values seen at each change in power-down then power-up order
  localparam logic [39:0] SEQ_SWITCHED  = {5'b01111, 5'b00111, 5'b00011, 5'b00001,
                                           5'b00011, 5'b00111, 5'b01111, 5'b11111};
  localparam logic [39:0] SEQ_RETENTIVE = {5'b01111, 5'b00111, 5'b00011, 5'b00010,
                                           5'b00011, 5'b00111, 5'b01111, 5'b11111};

  typedef enum logic [2:0] {
    OP_RESET, OP_IRQ_LEVEL, OP_FAST_PULSE, OP_FAST_CLR, OP_POWER_CYCLE, OP_DEBUG_RST
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [63:0] stim;
    logic [63:0] exp;
  } test_entry_t;

  logic                                        clk_i;
  logic                                        arst_n_i;
  logic                                        irq_software_i;
  logic                                        irq_external_i;
  mcu_irq_pkg::timer_irq_t                     timer_intr_i;
  mcu_irq_pkg::fast_irq_t                      fast_src_i;
  mcu_irq_pkg::fast_irq_t                      fast_clr_i;
  logic                                        core_sleep_i;
  logic                                        cpu_gate_en_i;
  logic                                        periph_off_i;
  mcu_pwr_pkg::bank_vec_t                      bank_off_i;
  logic                                        cpu_ack_ni;
  logic                                        periph_ack_ni;
  logic                                        debug_rst_ni;
  mcu_irq_pkg::irq_vec_t                       irq_o;
  mcu_irq_pkg::fast_irq_t                      irq_pending_o;
  mcu_pwr_pkg::pwr_ctrl_t                      cpu_ctrl_o;
  mcu_pwr_pkg::pwr_ctrl_t                      periph_ctrl_o;
  mcu_pwr_pkg::pwr_ctrl_t [`MCU_NUM_BANKS-1:0] bank_ctrl_o;
  logic                                        cpu_on_o;
  logic                                        periph_on_o;
  mcu_pwr_pkg::bank_vec_t                      bank_on_o;
  logic                                        cpu_rst_no;

  integer                 seed;
  int                     err_count;
  int                     pass_count;
  int                     fail_count;
  int                     n_tests;
  string                  test_name [NUM_TESTS];
  test_entry_t            test_tab [NUM_TESTS];
  mcu_pwr_pkg::pwr_ctrl_t ctrl_trace [$];
  int                     trace_cycle [$];

  mcu_ctrl_top uut (.*);

  bind power_domain_ctrl mcu_ctrl_chk ctrl_chk_i (.clk_i, .arst_n_i, .ctrl_i(ctrl_o));

  always #5 clk_i = ~clk_i;

  task automatic add_test(input string name, input op_e op, input logic [63:0] stim,
                          input logic [63:0] exp);
    test_name[n_tests] = name;
    test_tab[n_tests]  = '{op: op, stim: stim, exp: exp};
    n_tests++;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
      err_count++;
    end
  endtask

  // domain 0 is the cpu, 1 the peripherals, 2 and 3 the memory banks
  function automatic mcu_pwr_pkg::pwr_ctrl_t domain_ctrl(input int sel);
    case (sel)
      0: return cpu_ctrl_o;
      1: return periph_ctrl_o;
      2: return bank_ctrl_o[0];
      default: return bank_ctrl_o[1];
    endcase
  endfunction

  function automatic logic domain_on(input int sel);
    case (sel)
      0: return cpu_on_o;
      1: return periph_on_o;
      2: return bank_on_o[0];
      default: return bank_on_o[1];
    endcase
  endfunction

  task automatic drive_request(input int sel, input logic off);
    case (sel)
      0: begin
        // cpu sleeps on the core flag and wakes on a software interrupt
        if (off) begin
          core_sleep_i  = 1'b1;
          cpu_gate_en_i = 1'b1;
        end else begin
          irq_software_i = 1'b1;
        end
      end
      1: periph_off_i = off;
      2: bank_off_i[0] = off;
      default: bank_off_i[1] = off;
    endcase
  endtask

  task automatic drive_ack(input int sel, input logic ack_n);
    if (sel == 0) begin
      cpu_ack_ni = ack_n;
    end else if (sel == 1) begin
      periph_ack_ni = ack_n;
    end
  endtask

  task automatic power_cycle(input int sel, input logic [63:0] exp_seq, input string name);
    mcu_pwr_pkg::pwr_ctrl_t prev;
    mcu_pwr_pkg::pwr_ctrl_t cur;
    logic [63:0]            step_exp;
    logic                   rst_exp;
    int                     cnt;
    int                     ack_lo_at;
    int                     release_at;
    int                     ack_hi_at;
    int                     early_limit;
    bit                     done;
    ack_lo_at   = 4 + ($random(seed) & 7);
    release_at  = ack_lo_at + 2;
    ack_hi_at   = release_at + 1 + ($random(seed) & 7);
    early_limit = (sel < 2) ? ack_hi_at : release_at;
    ctrl_trace.delete();
    trace_cycle.delete();
    cnt  = 0;
    done = 1'b0;
    @(negedge clk_i);
    prev = domain_ctrl(sel);
    drive_request(sel, 1'b1);
    while (!done && cnt < PWR_TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
      cur = domain_ctrl(sel);
      if (cur != prev) begin
        ctrl_trace.push_back(cur);
        trace_cycle.push_back(cnt);
        prev = cur;
      end
      if (sel == 0) begin
        // reset bit of the step reached so far
        if (ctrl_trace.size() == 0 || ctrl_trace.size() > 8) begin
          rst_exp = 1'b1;
        end else begin
          rst_exp = exp_seq[5 * (8 - ctrl_trace.size()) + 2];
        end
        check_value({name, " cpu reset"}, 64'(rst_exp), 64'(cpu_rst_no));
      end
      if (domain_on(sel)) begin
        if (cnt <= early_limit) begin
          $display("%s: domain was on at cycle %0d, before its wake-up", name, cnt);
          err_count++;
        end
        done = 1'b1;
      end else begin
        if (cnt == ack_lo_at) drive_ack(sel, 1'b0);
        if (cnt == release_at) drive_request(sel, 1'b0);
        if (cnt == ack_hi_at) drive_ack(sel, 1'b1);
      end
    end
    if (!done) begin
      $display("%s: domain did not power up within %0d cycles", name, PWR_TIMEOUT);
      err_count++;
      drive_request(sel, 1'b0);
      drive_ack(sel, 1'b1);
    end
    if (sel == 0) begin
      core_sleep_i   = 1'b0;
      cpu_gate_en_i  = 1'b0;
      irq_software_i = 1'b0;
    end
    check_value({name, " steps"}, 64'd8, 64'(ctrl_trace.size()));
    for (int i = 0; i < ctrl_trace.size() && i < 8; i++) begin
      step_exp = (exp_seq >> (5 * (7 - i))) & 64'h1f;
      check_value($sformatf("%s step %0d", name, i), step_exp, 64'(ctrl_trace[i]));
      // each step takes one cycle apart from the switch waits
      if (i < 4) begin
        check_value($sformatf("%s step %0d cycle", name, i), 64'(i + 1),
                    64'(trace_cycle[i]));
      end else if (i > 5) begin
        check_value($sformatf("%s step %0d cycle", name, i), 64'(trace_cycle[i - 1] + 1),
                    64'(trace_cycle[i]));
      end
    end
    @(negedge clk_i);
  endtask

  task automatic run_entry(input int idx);
    test_entry_t t;
    string       name;
    t    = test_tab[idx];
    name = test_name[idx];
    case (t.op)
      OP_RESET: begin
        check_value({name, " irq"}, 64'h0, 64'(irq_o));
        check_value({name, " pending"}, 64'h0, 64'(irq_pending_o));
        check_value({name, " ctrl"}, 64'hf_ffff,
                    64'({cpu_ctrl_o, periph_ctrl_o, bank_ctrl_o}));
        check_value({name, " on"}, 64'hf, 64'({cpu_on_o, periph_on_o, bank_on_o}));
      end
      OP_IRQ_LEVEL: begin
        @(negedge clk_i);
        case (t.stim[1:0])
          2'd0: irq_software_i = 1'b1;
          2'd1: irq_external_i = 1'b1;
          default: timer_intr_i = 4'b0001;
        endcase
        @(negedge clk_i);
        check_value(name, t.exp, 64'(irq_o));
        irq_software_i = 1'b0;
        irq_external_i = 1'b0;
        timer_intr_i   = '0;
        @(negedge clk_i);
        check_value({name, " dropped"}, 64'h0, 64'(irq_o));
      end
      OP_FAST_PULSE: begin
        @(negedge clk_i);
        fast_src_i   = t.stim[15:0];
        timer_intr_i = t.stim[19:16];
        @(negedge clk_i);
        fast_src_i   = '0;
        timer_intr_i = '0;
        @(negedge clk_i);
        check_value(name, t.exp, 64'(irq_pending_o));
        check_value({name, " vector"}, t.exp, 64'(irq_o[`MCU_IRQ_FAST_BASE +: 16]));
      end
      OP_FAST_CLR: begin
        @(negedge clk_i);
        fast_clr_i = t.stim[15:0];
        fast_src_i = t.stim[31:16];
        @(negedge clk_i);
        fast_clr_i = '0;
        fast_src_i = '0;
        check_value(name, t.exp, 64'(irq_pending_o));
      end
      OP_POWER_CYCLE: power_cycle(int'(t.stim[3:0]), t.exp, name);
      OP_DEBUG_RST: begin
        @(negedge clk_i);
        debug_rst_ni = 1'b0;
        @(negedge clk_i);
        check_value(name, t.exp, 64'(cpu_rst_no));
        debug_rst_ni = 1'b1;
        @(negedge clk_i);
        check_value({name, " released"}, 64'h1, 64'(cpu_rst_no));
      end
      default: begin
        $display("%s: unknown operation in the test table", name);
        err_count++;
      end
    endcase
  endtask

  initial begin
    int errs_before;
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    irq_software_i = 1'b0;
    irq_external_i = 1'b0;
    timer_intr_i   = '0;
    fast_src_i     = '0;
    fast_clr_i     = '0;
    core_sleep_i   = 1'b0;
    cpu_gate_en_i  = 1'b0;
    periph_off_i   = 1'b0;
    bank_off_i     = '0;
    cpu_ack_ni     = 1'b1;
    periph_ack_ni  = 1'b1;
    debug_rst_ni   = 1'b1;
    seed           = 17116;
    err_count      = 0;
    pass_count     = 0;
    fail_count     = 0;
    n_tests        = 0;

    // fast stim holds timers in [19:16] and sources in [15:0]
    // clear stim holds sources in [31:16] and the clear mask in [15:0]
    add_test("reset_state", OP_RESET, 64'h0, 64'h0);
    add_test("irq_software", OP_IRQ_LEVEL, 64'd0, 64'h1 << `MCU_IRQ_SW_BIT);
    add_test("irq_external", OP_IRQ_LEVEL, 64'd1, 64'h1 << `MCU_IRQ_EXT_BIT);
    add_test("irq_timer0", OP_IRQ_LEVEL, 64'd2, 64'h1 << `MCU_IRQ_TIMER_BIT);
    add_test("fast5_pulse", OP_FAST_PULSE, 64'h0_0020, 64'h0020);
    add_test("timer1_pulse", OP_FAST_PULSE, 64'h2_0000, 64'h0021);
    add_test("timer2_pulse", OP_FAST_PULSE, 64'h4_0000, 64'h0023);
    add_test("timer3_pulse", OP_FAST_PULSE, 64'h8_0000, 64'h0027);
    add_test("clear_src_low", OP_FAST_CLR, 64'h0000_0020, 64'h0007);
    add_test("clear_src_high", OP_FAST_CLR, 64'h0001_0001, 64'h0007);
    add_test("clear_all", OP_FAST_CLR, 64'h0000_ffff, 64'h0000);
    add_test("periph_cycle", OP_POWER_CYCLE, 64'd1, 64'(SEQ_SWITCHED));
    add_test("bank0_cycle", OP_POWER_CYCLE, 64'd2, 64'(SEQ_RETENTIVE));
    add_test("bank1_cycle", OP_POWER_CYCLE, 64'd3, 64'(SEQ_RETENTIVE));
    add_test("cpu_sleep_wake", OP_POWER_CYCLE, 64'd0, 64'(SEQ_SWITCHED));
    add_test("debug_reset", OP_DEBUG_RST, 64'h0, 64'h0);

    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;

    for (int i = 0; i < n_tests; i++) begin
      errs_before = err_count;
      run_entry(i);
      if (err_count == errs_before) begin
        pass_count++;
        $display("%-16s passed", test_name[i]);
      end else begin
        fail_count++;
        $display("%-16s failed", test_name[i]);
      end
    end

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
